/* rtl/spdif_pkg.sv */
// ========================================
// S/PDIF transmitter shared definitions
// Widths, slot counts, preamble patterns
// and the state and preamble encodings
// ========================================
package spdif_pkg;

    // ========================================
    // Sub-frame word layout
    // ========================================
    // Audio bits per sub-frame, sent MSB first
    localparam int AUDIO_W = 24;
    // Control bits in the order V, U, C, P
    localparam int CTRL_W = 4;
    // Audio in the upper bits, control in the lower bits
    localparam int WORD_W = AUDIO_W + CTRL_W;

    // ========================================
    // Line timing
    // ========================================
    // One bit_clk_i cycle per half bit, 32 bit cells
    localparam int SLOTS_PER_SUBFRAME = 64;
    // Four preamble bit cells
    localparam int PREAMBLE_SLOTS = 8;
    localparam int SLOT_W = $clog2(SLOTS_PER_SUBFRAME);
    // 192 frames of two sub-frames each
    localparam int SUBFRAMES_PER_BLOCK = 384;
    localparam int BLOCK_W = $clog2(SUBFRAMES_PER_BLOCK);

    // Preamble patterns for a high line level before the sub-frame
    // Bit 7 goes out first; the encoder complements them after a low level
    localparam logic [PREAMBLE_SLOTS-1:0] PREAMBLE_B = 8'b0001_0111;
    localparam logic [PREAMBLE_SLOTS-1:0] PREAMBLE_M = 8'b0001_1101;
    localparam logic [PREAMBLE_SLOTS-1:0] PREAMBLE_W = 8'b0001_1011;

    // ========================================
    // Encodings
    // ========================================
    // B opens a block, M marks the other left sub-frames, W the right ones
    typedef enum logic [1:0] {
        PRE_B,
        PRE_M,
        PRE_W
    } preamble_e;

    // Transmitter phases within a sub-frame
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_SAMPLE,
        ST_CONTROL
    } tx_state_e;

endpackage

/* rtl/sample_capture.sv */
// ========================================
// Sub-frame word intake
// Four-phase req/ack handshake into a
// single holding register
// ========================================
module sample_capture (
    input  logic                          bit_clk_i,
    input  logic                          reset_i,
    input  logic                          sample_req_i,
    input  logic [spdif_pkg::AUDIO_W-1:0] sample_data_i,
    input  logic [spdif_pkg::CTRL_W-1:0]  sample_ctrl_i,
    // Word moved into the encoder this cycle
    input  logic                          load_i,
    output logic                          sample_ack_o,
    output logic                          word_valid_o,
    output logic [spdif_pkg::WORD_W-1:0]  word_o
);

    logic                         ack_q;
    logic                         valid_q;
    logic [spdif_pkg::WORD_W-1:0] word_q;
    // Accept only with an empty buffer and a finished previous handshake
    logic                         take;

    assign take = sample_req_i && !ack_q && !valid_q;

    // ========================================
    // Handshake and valid flag
    // ========================================
    always_ff @(posedge bit_clk_i or posedge reset_i) begin
        if (reset_i) begin
            ack_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            // ack rises with the latch, drops once req has gone low
            if (take) begin
                ack_q <= 1'b1;
            end else if (ack_q && !sample_req_i) begin
                ack_q <= 1'b0;
            end
            // Buffer fills on take, empties when the encoder takes the word
            if (take) begin
                valid_q <= 1'b1;
            end else if (load_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    // Holding register, audio on top and V, U, C, P at the bottom
    always_ff @(posedge bit_clk_i) begin
        if (take) begin
            word_q <= {sample_data_i, sample_ctrl_i};
        end
    end

    assign sample_ack_o = ack_q;
    assign word_valid_o = valid_q;
    assign word_o       = word_q;

endmodule

/* rtl/subframe_fsm.sv */
// ========================================
// Sub-frame sequencer
// Walks idle, preamble, sample and control
// phases and starts each sub-frame
// ========================================
module subframe_fsm (
    input  logic                 bit_clk_i,
    input  logic                 reset_i,
    input  logic                 word_valid_i,
    // Phase ends from the slot timer
    input  logic                 preamble_end_i,
    input  logic                 sample_end_i,
    input  logic                 subframe_end_i,
    output spdif_pkg::tx_state_e state_o,
    output logic                 load_o,
    output logic                 streaming_o
);

    spdif_pkg::tx_state_e state_q;
    spdif_pkg::tx_state_e state_d;
    logic                 load;
    logic                 streaming_q;

    // ========================================
    // Next state and load
    // ========================================
    always_comb begin
        state_d = state_q;
        load    = 1'b0;
        case (state_q)
            spdif_pkg::ST_IDLE: begin
                // Start as soon as a word sits in the buffer
                if (word_valid_i) begin
                    load    = 1'b1;
                    state_d = spdif_pkg::ST_PREAMBLE;
                end
            end
            spdif_pkg::ST_PREAMBLE: begin
                if (preamble_end_i) begin
                    state_d = spdif_pkg::ST_SAMPLE;
                end
            end
            spdif_pkg::ST_SAMPLE: begin
                if (sample_end_i) begin
                    state_d = spdif_pkg::ST_CONTROL;
                end
            end
            spdif_pkg::ST_CONTROL: begin
                if (subframe_end_i) begin
                    // Back to back with the next word, else stop the stream
                    if (word_valid_i) begin
                        load    = 1'b1;
                        state_d = spdif_pkg::ST_PREAMBLE;
                    end else begin
                        state_d = spdif_pkg::ST_IDLE;
                    end
                end
            end
            default: begin
                state_d = spdif_pkg::ST_IDLE;
            end
        endcase
    end

    // ========================================
    // State and streaming flag
    // ========================================
    always_ff @(posedge bit_clk_i or posedge reset_i) begin
        if (reset_i) begin
            state_q     <= spdif_pkg::ST_IDLE;
            streaming_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            // Rises with the first preamble half-bit, falls on underrun
            streaming_q <= (state_d != spdif_pkg::ST_IDLE);
        end
    end

    assign state_o     = state_q;
    assign load_o      = load;
    assign streaming_o = streaming_q;

endmodule

/* rtl/slot_timer.sv */
// ========================================
// Slot and block timer
// Half-bit slot within a sub-frame, and
// sub-frame index within a 384 block
// ========================================
module slot_timer (
    input  logic                         bit_clk_i,
    input  logic                         reset_i,
    input  spdif_pkg::tx_state_e         state_i,
    input  logic                         load_i,
    output logic                         preamble_end_o,
    output logic                         sample_end_o,
    output logic                         subframe_end_o,
    // Slot currently on the line
    output logic [spdif_pkg::SLOT_W-1:0] slot_o,
    output spdif_pkg::preamble_e         preamble_kind_o
);

    logic [spdif_pkg::SLOT_W-1:0]  slot_q;
    // Index of the next sub-frame to start
    logic [spdif_pkg::BLOCK_W-1:0] block_q;

    // ========================================
    // Phase ends on the last slot of each phase
    // ========================================
    assign preamble_end_o = (state_i == spdif_pkg::ST_PREAMBLE) &&
        (slot_q == spdif_pkg::SLOT_W'(spdif_pkg::PREAMBLE_SLOTS - 1));
    // Two slots per audio bit after the preamble
    assign sample_end_o = (state_i == spdif_pkg::ST_SAMPLE) &&
        (slot_q == spdif_pkg::SLOT_W'(spdif_pkg::PREAMBLE_SLOTS + 2 * spdif_pkg::AUDIO_W - 1));
    assign subframe_end_o = (state_i == spdif_pkg::ST_CONTROL) &&
        (slot_q == spdif_pkg::SLOT_W'(spdif_pkg::SLOTS_PER_SUBFRAME - 1));

    always_ff @(posedge bit_clk_i or posedge reset_i) begin
        if (reset_i) begin
            slot_q  <= '0;
            block_q <= '0;
        end else begin
            // Slot count, natural wrap at 64
            if (load_i) begin
                slot_q <= '0;
            end else if (state_i != spdif_pkg::ST_IDLE) begin
                slot_q <= slot_q + spdif_pkg::SLOT_W'(1);
            end
            // Block count advances per sub-frame, restarts on underrun
            if (load_i) begin
                if (block_q == spdif_pkg::BLOCK_W'(spdif_pkg::SUBFRAMES_PER_BLOCK - 1)) begin
                    block_q <= '0;
                end else begin
                    block_q <= block_q + spdif_pkg::BLOCK_W'(1);
                end
            end else if (subframe_end_o) begin
                block_q <= '0;
            end
        end
    end

    // B opens the block, even indexes are left (M), odd are right (W)
    always_comb begin
        if (block_q == '0) begin
            preamble_kind_o = spdif_pkg::PRE_B;
        end else if (block_q[0]) begin
            preamble_kind_o = spdif_pkg::PRE_W;
        end else begin
            preamble_kind_o = spdif_pkg::PRE_M;
        end
    end

    assign slot_o = slot_q;

endmodule

/* rtl/bmc_encoder.sv */
// ========================================
// Biphase-mark line encoder
// Picks the preamble, shifts the word out
// MSB first and drives the S/PDIF line
// ========================================
module bmc_encoder (
    input  logic                         bit_clk_i,
    input  logic                         reset_i,
    input  logic                         load_i,
    input  logic [spdif_pkg::WORD_W-1:0] word_i,
    input  spdif_pkg::preamble_e         preamble_kind_i,
    input  spdif_pkg::tx_state_e         state_i,
    // Slot currently on the line
    input  logic [spdif_pkg::SLOT_W-1:0] slot_i,
    output logic                         spdif_o
);

    logic                                 spdif_q;
    logic [spdif_pkg::WORD_W-1:0]         word_q;
    logic [spdif_pkg::PREAMBLE_SLOTS-1:0] preamble_q;
    logic [spdif_pkg::PREAMBLE_SLOTS-1:0] pattern;
    // Slot that goes out on the coming edge
    logic [spdif_pkg::SLOT_W-1:0]         next_slot;
    logic                                 active;
    logic                                 in_preamble;

    assign next_slot   = slot_i + spdif_pkg::SLOT_W'(1);
    // Nothing to send in idle or past the last slot
    assign active      = (state_i != spdif_pkg::ST_IDLE) && (next_slot != '0);
    assign in_preamble = (next_slot < spdif_pkg::SLOT_W'(spdif_pkg::PREAMBLE_SLOTS));

    // ========================================
    // Preamble selection
    // ========================================
    always_comb begin
        case (preamble_kind_i)
            spdif_pkg::PRE_B: pattern = spdif_pkg::PREAMBLE_B;
            spdif_pkg::PRE_M: pattern = spdif_pkg::PREAMBLE_M;
            default:          pattern = spdif_pkg::PREAMBLE_W;
        endcase
    end

    // ========================================
    // Word and preamble registers
    // ========================================
    always_ff @(posedge bit_clk_i) begin
        if (load_i) begin
            word_q     <= word_i;
            // Complement after a low level so the first half-bit inverts it
            preamble_q <= spdif_q ? pattern : ~pattern;
        end else if (active && !in_preamble && next_slot[0]) begin
            // Bit cell done after its second half
            word_q <= word_q << 1;
        end
    end

    // ========================================
    // Line driver
    // ========================================
    always_ff @(posedge bit_clk_i or posedge reset_i) begin
        if (reset_i) begin
            spdif_q <= 1'b1;
        end else if (load_i) begin
            // First preamble half-bit, always the inverse of the line
            spdif_q <= ~spdif_q;
        end else if (active) begin
            if (in_preamble) begin
                // Pattern bit 7 is slot 0
                spdif_q <= preamble_q[3'(spdif_pkg::PREAMBLE_SLOTS - 1) - next_slot[2:0]];
            end else if (!next_slot[0]) begin
                // Transition at every cell boundary
                spdif_q <= ~spdif_q;
            end else if (word_q[spdif_pkg::WORD_W-1]) begin
                // Mid-cell transition marks a 1
                spdif_q <= ~spdif_q;
            end
        end
    end

    assign spdif_o = spdif_q;

endmodule

/* rtl/spdif_tx_top.sv */
// ========================================
// S/PDIF transmitter top level
// Takes 28-bit sub-frame words over a
// four-phase req/ack handshake and sends
// them as biphase-mark sub-frames
// ========================================
module spdif_tx_top (
    input  logic                          bit_clk_i,
    input  logic                          reset_i,
    // Four-phase word source
    input  logic                          sample_req_i,
    input  logic [spdif_pkg::AUDIO_W-1:0] sample_data_i,
    input  logic [spdif_pkg::CTRL_W-1:0]  sample_ctrl_i,
    output logic                          sample_ack_o,
    // Line side
    output logic                          streaming_o,
    output logic                          spdif_o
);

    // Holding buffer to encoder and FSM
    logic                         word_valid;
    logic [spdif_pkg::WORD_W-1:0] word;
    // Start of a sub-frame, frees the buffer
    logic                         load;
    spdif_pkg::tx_state_e         state;
    // Phase ends from the timer
    logic                         preamble_end;
    logic                         sample_end;
    logic                         subframe_end;
    logic [spdif_pkg::SLOT_W-1:0] slot;
    spdif_pkg::preamble_e         preamble_kind;

    // ========================================
    // Word intake
    // ========================================
    sample_capture capture0 (
        .bit_clk_i     (bit_clk_i),
        .reset_i       (reset_i),
        .sample_req_i  (sample_req_i),
        .sample_data_i (sample_data_i),
        .sample_ctrl_i (sample_ctrl_i),
        .load_i        (load),
        .sample_ack_o  (sample_ack_o),
        .word_valid_o  (word_valid),
        .word_o        (word)
    );

    // ========================================
    // Sequencing and timing
    // ========================================
    subframe_fsm fsm0 (
        .bit_clk_i      (bit_clk_i),
        .reset_i        (reset_i),
        .word_valid_i   (word_valid),
        .preamble_end_i (preamble_end),
        .sample_end_i   (sample_end),
        .subframe_end_i (subframe_end),
        .state_o        (state),
        .load_o         (load),
        .streaming_o    (streaming_o)
    );

    slot_timer timer0 (
        .bit_clk_i       (bit_clk_i),
        .reset_i         (reset_i),
        .state_i         (state),
        .load_i          (load),
        .preamble_end_o  (preamble_end),
        .sample_end_o    (sample_end),
        .subframe_end_o  (subframe_end),
        .slot_o          (slot),
        .preamble_kind_o (preamble_kind)
    );

    // ========================================
    // Line driver
    // ========================================
    bmc_encoder encoder0 (
        .bit_clk_i       (bit_clk_i),
        .reset_i         (reset_i),
        .load_i          (load),
        .word_i          (word),
        .preamble_kind_i (preamble_kind),
        .state_i         (state),
        .slot_i          (slot),
        .spdif_o         (spdif_o)
    );

endmodule

/* bench/spdif_tx_chk.sv */
// ========================================
// S/PDIF transmitter line checker
// Decodes the line back into words and
// compares them with the accepted ones
// ========================================
module spdif_tx_chk (
    input logic                          bit_clk_i,
    input logic                          reset_i,
    input logic                          sample_req_i,
    input logic [spdif_pkg::AUDIO_W-1:0] sample_data_i,
    input logic [spdif_pkg::CTRL_W-1:0]  sample_ctrl_i,
    input logic                          sample_ack_o,
    input logic                          streaming_o,
    input logic                          spdif_o
);

    // IEC 60958 preambles after a high level, first half-bit in bit 7
    localparam logic [7:0] B_AFTER_HIGH = 8'b0001_0111;
    localparam logic [7:0] M_AFTER_HIGH = 8'b0001_1101;
    localparam logic [7:0] W_AFTER_HIGH = 8'b0001_1011;

    int                           fail_count = 0;
    logic [spdif_pkg::WORD_W-1:0] accepted_q[$];
    logic                         ack_d;
    logic                         stream_d;
    // Line level at the last eight edges, newest in bit 0
    logic [7:0]                   hist_q;
    // Slot seen at the previous edge and at this one
    logic [5:0]                   slot_d;
    logic [5:0]                   slot_now;
    logic [8:0]                   subframe_q;
    logic [spdif_pkg::WORD_W-2:0] bits_q;
    logic                         toggled;
    logic                         done_q;
    logic [spdif_pkg::WORD_W-1:0] got_q;
    logic [spdif_pkg::WORD_W-1:0] exp_q;
    logic [7:0]                   pre_kind;
    logic [7:0]                   exp_preamble;

    // Slot 0 at the rise of streaming_o, then one slot per cycle
    assign slot_now = (streaming_o && !stream_d) ? 6'd0 : slot_d + 6'd1;
    assign toggled  = spdif_o != hist_q[0];
    assign pre_kind = (subframe_q == '0) ? B_AFTER_HIGH :
        (subframe_q[0] ? W_AFTER_HIGH : M_AFTER_HIGH);
    // At slot 7 the level before slot 0 is eight edges back
    assign exp_preamble = hist_q[7] ? pre_kind : ~pre_kind;

    // ========================================
    // Reference decoder
    // ========================================
    always @(posedge bit_clk_i or posedge reset_i) begin
        if (reset_i) begin
            ack_d    <= 1'b0;
            stream_d <= 1'b0;
            hist_q   <= '1;
            done_q   <= 1'b0;
            accepted_q.delete();
        end else begin
            ack_d    <= sample_ack_o;
            stream_d <= streaming_o;
            hist_q   <= {hist_q[6:0], spdif_o};
            done_q   <= 1'b0;
            // Source still holds the latched word when ack is seen high
            if (sample_ack_o && !ack_d) begin
                accepted_q.push_back({sample_data_i, sample_ctrl_i});
            end
            if (streaming_o) begin
                slot_d <= slot_now;
                // Block index restarts with each stream
                if (slot_now == 6'd0) begin
                    subframe_q <= (!stream_d || subframe_q == 9'd383) ? '0 : subframe_q + 9'd1;
                end
                // Second half of each data cell, slots 9 to 63
                if (slot_now[0] && slot_now >= 6'd9) begin
                    bits_q <= {bits_q[spdif_pkg::WORD_W-3:0], toggled};
                end
                if (slot_now == 6'd63) begin
                    done_q <= 1'b1;
                    got_q  <= {bits_q, toggled};
                    if (accepted_q.size() > 0) begin
                        exp_q <= accepted_q.pop_front();
                    end else begin
                        // No word accepted, so nothing can match
                        exp_q <= ~{bits_q, toggled};
                    end
                end
            end
        end
    end

    // ========================================
    // Assertions
    // ========================================
    // Outputs still hold their reset values on the first edge after release
    reset_values: assert property (@(posedge bit_clk_i)
        $fell(reset_i) |-> spdif_o && !sample_ack_o && !streaming_o) else begin
        fail_count++;
        $error("Outputs not at their reset values when reset_i fell");
    end

    // ack follows req in both directions, req drops only after ack
    handshake_order: assert property (@(posedge bit_clk_i) disable iff (reset_i)
        (!$rose(sample_ack_o) || sample_req_i) && (!$fell(sample_ack_o) || !sample_req_i)
        && (!$fell(sample_req_i) || sample_ack_o)) else begin
        fail_count++;
        $error("sample_req_i and sample_ack_o left the four-phase order");
    end

    cell_boundary: assert property (@(posedge bit_clk_i) disable iff (reset_i)
        streaming_o && !slot_now[0] && (slot_now == 6'd0 || slot_now >= 6'd8) |-> toggled)
        else begin
        fail_count++;
        $error("spdif_o did not toggle at slot %0d", $sampled(slot_now));
    end

    preamble_pattern: assert property (@(posedge bit_clk_i) disable iff (reset_i)
        streaming_o && slot_now == 6'd7 |-> {hist_q[6:0], spdif_o} == exp_preamble) else begin
        fail_count++;
        $error("FAIL spdif_o preamble expected %h got %h",
            $sampled(exp_preamble), $sampled({hist_q[6:0], spdif_o}));
    end

    word_match: assert property (@(posedge bit_clk_i) disable iff (reset_i)
        done_q |-> got_q == exp_q) else begin
        fail_count++;
        $error("FAIL spdif_o word expected %h got %h", $sampled(exp_q), $sampled(got_q));
    end

    // Stream stops only after slot 63 and the line then holds
    idle_line: assert property (@(posedge bit_clk_i) disable iff (reset_i)
        !streaming_o |-> !toggled && (!stream_d || slot_d == 6'd63)) else begin
        fail_count++;
        $error("spdif_o moved or streaming_o fell inside a sub-frame");
    end

endmodule

/* bench/tb_spdif_tx.sv */
// ========================================
// S/PDIF transmitter testbench
// Four-phase word source with an underrun
// gap; checks run in the bound checker
// ========================================
module tb_spdif_tx;

    localparam int RESET_CYCLES = 10;
    // First run crosses a 384 block boundary
    localparam int FIRST_RUN = 410;
    localparam int SECOND_RUN = 20;
    localparam int GAP_CYCLES = 20;
    // 430 sub-frames of 64 cycles is about 27.5k, plus reset, gap and slack
    localparam int TIMEOUT_CYCLES = 30000;

    logic                          bit_clk_i;
    logic                          reset_i;
    logic                          sample_req_i;
    logic [spdif_pkg::AUDIO_W-1:0] sample_data_i;
    logic [spdif_pkg::CTRL_W-1:0]  sample_ctrl_i;
    logic                          sample_ack_o;
    logic                          streaming_o;
    logic                          spdif_o;
    logic [31:0]                   rand_state;
    int                            cycle_count = 0;
    int                            words_sent = 0;

    spdif_tx_top dut0 (
        .bit_clk_i     (bit_clk_i),
        .reset_i       (reset_i),
        .sample_req_i  (sample_req_i),
        .sample_data_i (sample_data_i),
        .sample_ctrl_i (sample_ctrl_i),
        .sample_ack_o  (sample_ack_o),
        .streaming_o   (streaming_o),
        .spdif_o       (spdif_o)
    );

    // Line checker sits inside the DUT
    bind spdif_tx_top spdif_tx_chk chk0 (.*);

    always #4 bit_clk_i = ~bit_clk_i;

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // One four-phase transfer, waits as long as the buffer is full
    task automatic send_word();
        logic [spdif_pkg::AUDIO_W-1:0] audio;
        logic [spdif_pkg::CTRL_W-1:0]  ctrl;
        rand_state = next_random(rand_state);
        audio = rand_state[31:8];
        // Random V, U, C and P, so odd parity words also leave the line low
        ctrl  = rand_state[7:4];
        @(posedge bit_clk_i);
        sample_data_i <= audio;
        sample_ctrl_i <= ctrl;
        sample_req_i  <= 1'b1;
        do @(posedge bit_clk_i); while (!sample_ack_o);
        sample_req_i <= 1'b0;
        do @(posedge bit_clk_i); while (sample_ack_o);
        words_sent++;
    endtask

    task automatic wait_line_idle();
        do @(posedge bit_clk_i); while (streaming_o);
    endtask

    task automatic report_counts();
        $display("Words sent %0d, cycles %0d, assertion failures %0d",
            words_sent, cycle_count, dut0.chk0.fail_count);
    endtask

    // ========================================
    // Run limit
    // ========================================
    always @(posedge bit_clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
            report_counts();
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ========================================
    // Stimulus
    // ========================================
    initial begin
        bit_clk_i     = 1'b0;
        reset_i       = 1'b1;
        sample_req_i  = 1'b0;
        sample_data_i = '0;
        sample_ctrl_i = '0;
        rand_state    = 32'he9b8_5f30;
        repeat (RESET_CYCLES) @(posedge bit_clk_i);
        reset_i <= 1'b0;
        // Back to back words keep the line streaming
        repeat (FIRST_RUN) send_word();
        // Source goes quiet until the line stops, then restarts
        wait_line_idle();
        repeat (GAP_CYCLES) @(posedge bit_clk_i);
        repeat (SECOND_RUN) send_word();
        wait_line_idle();
        repeat (4) @(posedge bit_clk_i);
        report_counts();
        if (dut0.chk0.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* list.f */
rtl/spdif_pkg.sv
rtl/sample_capture.sv
rtl/subframe_fsm.sv
rtl/slot_timer.sv
rtl/bmc_encoder.sv
rtl/spdif_tx_top.sv
bench/spdif_tx_chk.sv
bench/tb_spdif_tx.sv

/* Bender.yml */
package:
  name: spdif_tx

sources:
  - rtl/spdif_pkg.sv
  - rtl/sample_capture.sv
  - rtl/subframe_fsm.sv
  - rtl/slot_timer.sv
  - rtl/bmc_encoder.sv
  - rtl/spdif_tx_top.sv
  - target: test
    files:
      - bench/spdif_tx_chk.sv
      - bench/tb_spdif_tx.sv
